//--- Bender.yml
package:
  name: nn_layer_cu

sources:
  - files:
      - cu_pkg.sv
      - cu_scratch.sv
      - cu_csr.sv
      - cu_fsm.sv
      - cu_dma.sv
      - cu_sequencer.sv
      - cu_top.sv
  - target: simulation
    files:
      - cu_assertions.sv
      - tb_cu_top.sv

//--- cu_assertions.sv
`timescale 1ns/100ps

module cu_assertions
    import cu_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       busy,
    input logic       layer_done,
    input logic       phase_fetch,
    input logic       phase_compute,
    input logic       phase_writeback,
    input logic       mem_rd_en,
    input logic       mem_wr_en,
    input layer_cfg_t cfg
);

    int             fail_cnt = 0;
    logic [LEN_W:0] wr_cnt;

    // memory writes seen since the last layer_done
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_cnt <= '0;
        end else if (layer_done) begin
            wr_cnt <= '0;
        end else if (mem_wr_en) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    // protocol rules
    ////////////////////////////////////////
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        layer_done |-> $past(phase_writeback) ##1 !layer_done)
        else begin
            $error("layer_done is not a single pulse after writeback");
            fail_cnt++;
        end

    a_no_rd_wr: assert property (@(posedge clk) disable iff (rst)
        !(mem_rd_en && mem_wr_en))
        else begin
            $error("memory read and write strobes high together");
            fail_cnt++;
        end

    a_rd_in_fetch: assert property (@(posedge clk) disable iff (rst)
        mem_rd_en |-> phase_fetch)
        else begin
            $error("memory read outside the fetch phase");
            fail_cnt++;
        end

    a_wr_in_wb: assert property (@(posedge clk) disable iff (rst)
        mem_wr_en |-> phase_writeback)
        else begin
            $error("memory write outside the writeback phase");
            fail_cnt++;
        end

    a_wr_count: assert property (@(posedge clk) disable iff (rst)
        layer_done |-> (wr_cnt == cfg.ofm_len))
        else begin
            $error("memory write count differs from ofm_len");
            fail_cnt++;
        end

    // phase order, fetch then compute then writeback
    a_fetch_first: assert property (@(posedge clk) disable iff (rst)
        $rose(phase_fetch) |-> $past(!busy))
        else begin
            $error("fetch phase did not start from idle");
            fail_cnt++;
        end

    a_compute_order: assert property (@(posedge clk) disable iff (rst)
        $rose(phase_compute) |-> $past(phase_fetch, 2))
        else begin
            $error("compute phase not preceded by fetch");
            fail_cnt++;
        end

    a_wb_order: assert property (@(posedge clk) disable iff (rst)
        $rose(phase_writeback) |-> $past(phase_compute))
        else begin
            $error("writeback phase not preceded by compute");
            fail_cnt++;
        end

    a_idle_after_rst: assert property (@(posedge clk)
        $fell(rst) |-> !busy)
        else begin
            $error("busy high in the cycle after reset release");
            fail_cnt++;
        end

endmodule

bind cu_top cu_assertions assert_i (
    .clk(clk), .rst(rst), .busy(busy), .layer_done(layer_done),
    .phase_fetch(phase_fetch), .phase_compute(phase_compute),
    .phase_writeback(phase_writeback), .mem_rd_en(mem_rd_en), .mem_wr_en(mem_wr_en),
    .cfg(cfg)
);

//--- cu_csr.sv
`timescale 1ns/100ps

module cu_csr
    import cu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              csr_we,
    input  cu_csr_addr_t      csr_addr,
    input  logic [DATA_W-1:0] csr_wdata,
    output layer_cfg_t        cfg,
    output logic              start_decoded
);

    ////////////////////////////////////////
    // configuration registers
    ////////////////////////////////////////
    // contents survive a layer so the host may reuse them
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cfg <= '0;
        end else if (csr_we) begin
            case (csr_addr)
                CSR_IFM_BASE: begin
                    cfg.ifm_base <= csr_wdata[ADDR_W-1:0];
                end
                CSR_OFM_BASE: begin
                    cfg.ofm_base <= csr_wdata[ADDR_W-1:0];
                end
                CSR_LEN: begin
                    // ifm in low byte, ofm in high byte
                    cfg.ifm_len <= csr_wdata[LEN_W-1:0];
                    cfg.ofm_len <= csr_wdata[8 +: LEN_W];
                end
                CSR_OPCODE: begin
                    cfg.opcode <= cu_opcode_t'(csr_wdata[1:0]);
                end
                CSR_BIAS: begin
                    cfg.bias <= csr_wdata;
                end
                default: begin
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // go strobe
    ////////////////////////////////////////
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            start_decoded <= 1'b0;
        end else begin
            start_decoded <= csr_we && (csr_addr == CSR_CTRL) && csr_wdata[0];
        end
    end

endmodule

//--- cu_dma.sv
`timescale 1ns/100ps

module cu_dma
    import cu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  mem_req_t          rd_req,
    input  mem_req_t          wr_req,
    input  logic [DATA_W-1:0] mem_rdata,
    input  logic [DATA_W-1:0] ofm_rdata,
    output logic              mem_read_done,
    output logic              mem_write_done,
    output logic              mem_rd_en,
    output logic              mem_wr_en,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [DATA_W-1:0] mem_wdata,
    output logic              ifm_we,
    output logic [BUF_AW-1:0] ifm_waddr,
    output logic [DATA_W-1:0] ifm_wdata,
    output logic              ofm_re,
    output logic [BUF_AW-1:0] ofm_raddr
);

    typedef enum logic [1:0] {
        D_IDLE,
        D_READ,
        D_WRITE,
        D_DONE
    } dma_state_t;

    dma_state_t        state;
    logic [LEN_W-1:0]  cnt;
    logic              pend;
    logic [BUF_AW-1:0] pend_idx;
    logic              dir_rd;
    mem_req_t          act;
    logic              issue;

    // request being served
    assign act   = dir_rd ? rd_req : wr_req;
    assign issue = ((state == D_READ) || (state == D_WRITE)) && (cnt != act.len);

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state  <= D_IDLE;
            cnt    <= '0;
            pend   <= 1'b0;
            dir_rd <= 1'b0;
        end else begin
            case (state)
                D_IDLE: begin
                    cnt  <= '0;
                    pend <= 1'b0;
                    if (rd_req.req) begin
                        state  <= D_READ;
                        dir_rd <= 1'b1;
                    end else if (wr_req.req) begin
                        state  <= D_WRITE;
                        dir_rd <= 1'b0;
                    end
                end
                D_READ, D_WRITE: begin
                    if (issue) begin
                        cnt <= cnt + 1'b1;
                    end
                    pend <= issue;
                    // last word has left the pipeline
                    if (!issue && pend) begin
                        state <= D_DONE;
                    end
                end
                default: begin
                    state <= D_IDLE;
                end
            endcase
        end
    end

    // index of the word that lands next cycle
    always_ff @(posedge clk) begin
        if (issue) begin
            pend_idx <= cnt[BUF_AW-1:0];
        end
    end

    ////////////////////////////////////////
    // memory and buffer side
    ////////////////////////////////////////
    assign mem_rd_en = (state == D_READ) && issue;
    assign mem_wr_en = (state == D_WRITE) && pend;
    assign mem_addr  = act.addr + ((state == D_READ) ? ADDR_W'(cnt) : ADDR_W'(pend_idx));
    assign mem_wdata = ofm_rdata;

    assign ifm_we    = (state == D_READ) && pend;
    assign ifm_waddr = pend_idx;
    assign ifm_wdata = mem_rdata;
    assign ofm_re    = (state == D_WRITE) && issue;
    assign ofm_raddr = cnt[BUF_AW-1:0];

    assign mem_read_done  = (state == D_DONE) && dir_rd;
    assign mem_write_done = (state == D_DONE) && !dir_rd;

endmodule

//--- cu_fsm.sv
`timescale 1ns/100ps

module cu_fsm
    import cu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start_decoded,
    input  layer_cfg_t cfg,
    input  logic       mem_read_done,
    input  logic       mem_write_done,
    input  logic       seq_done,
    output mem_req_t   rd_req,
    output mem_req_t   wr_req,
    output logic       seq_start,
    output logic       phase_fetch,
    output logic       phase_compute,
    output logic       phase_writeback,
    output logic       busy,
    output logic       layer_done
);

    cu_state_t state;
    cu_state_t n_state;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= n_state;
        end
    end

    ////////////////////////////////////////
    // next state and outputs
    ////////////////////////////////////////
    always_comb begin
        n_state         = state;
        rd_req          = '0;
        wr_req          = '0;
        seq_start       = 1'b0;
        phase_fetch     = 1'b0;
        phase_compute   = 1'b0;
        phase_writeback = 1'b0;
        layer_done      = 1'b0;

        case (state)
            S_IDLE: begin
                // go is only looked at here, so repeats while busy drop out
                if (start_decoded) begin
                    n_state = S_FETCH_IFM;
                end
            end
            S_FETCH_IFM: begin
                phase_fetch = 1'b1;
                rd_req.req  = 1'b1;
                rd_req.addr = cfg.ifm_base;
                rd_req.len  = cfg.ifm_len;
                if (mem_read_done) begin
                    n_state = S_START_SEQ;
                end
            end
            S_START_SEQ: begin
                seq_start = 1'b1;
                n_state   = S_WAIT_SEQ;
            end
            S_WAIT_SEQ: begin
                phase_compute = 1'b1;
                if (seq_done) begin
                    n_state = S_WRITEBACK;
                end
            end
            S_WRITEBACK: begin
                phase_writeback = 1'b1;
                wr_req.req      = 1'b1;
                wr_req.addr     = cfg.ofm_base;
                wr_req.len      = cfg.ofm_len;
                if (mem_write_done) begin
                    n_state = S_DONE;
                end
            end
            S_DONE: begin
                layer_done = 1'b1;
                n_state    = S_IDLE;
            end
            default: begin
                n_state = S_IDLE;
            end
        endcase
    end

    assign busy = (state != S_IDLE);

endmodule

//--- cu_pkg.sv
package cu_pkg;

    ////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////
    localparam int ADDR_W    = 12;
    localparam int DATA_W    = 16;
    localparam int BUF_DEPTH = 64;
    localparam int BUF_AW    = 6;
    // legal layer length 1 to 64
    localparam int LEN_W     = 7;
    localparam int CSR_AW    = 3;

    // signed saturation limits for the bias add
    localparam logic [DATA_W-1:0] SAT_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam logic [DATA_W-1:0] SAT_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    ////////////////////////////////////////
    // enums
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        OP_PASS,
        OP_RELU,
        OP_BIAS,
        OP_HALVE
    } cu_opcode_t;

    typedef enum logic [CSR_AW-1:0] {
        CSR_CTRL,
        CSR_IFM_BASE,
        CSR_OFM_BASE,
        CSR_LEN,
        CSR_OPCODE,
        CSR_BIAS
    } cu_csr_addr_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH_IFM,
        S_START_SEQ,
        S_WAIT_SEQ,
        S_WRITEBACK,
        S_DONE
    } cu_state_t;

    ////////////////////////////////////////
    // structs
    ////////////////////////////////////////
    typedef struct packed {
        logic [ADDR_W-1:0] ifm_base;
        logic [ADDR_W-1:0] ofm_base;
        logic [LEN_W-1:0]  ifm_len;
        logic [LEN_W-1:0]  ofm_len;
        cu_opcode_t        opcode;
        logic [DATA_W-1:0] bias;
    } layer_cfg_t;

    // level request, held until the matching done pulse
    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } mem_req_t;

endpackage

//--- cu_scratch.sv
`timescale 1ns/100ps

module cu_scratch
    import cu_pkg::*;
(
    input  logic              clk,
    input  logic              we,
    input  logic [BUF_AW-1:0] waddr,
    input  logic [DATA_W-1:0] wdata,
    input  logic              re,
    input  logic [BUF_AW-1:0] raddr,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0] mem [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // data valid the cycle after re
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- cu_sequencer.sv
`timescale 1ns/100ps

module cu_sequencer
    import cu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              seq_start,
    input  layer_cfg_t        cfg,
    input  logic [DATA_W-1:0] ifm_rdata,
    output logic              seq_done,
    output logic              ifm_re,
    output logic [BUF_AW-1:0] ifm_raddr,
    output logic              ofm_we,
    output logic [BUF_AW-1:0] ofm_waddr,
    output logic [DATA_W-1:0] ofm_wdata
);

    logic              active;
    logic [LEN_W-1:0]  cnt;
    logic              issue;
    logic              v2;
    logic [BUF_AW-1:0] widx;
    logic [DATA_W:0]   sum;
    logic [DATA_W-1:0] result;

    assign issue = active && (cnt != cfg.ifm_len);

    ////////////////////////////////////////
    // stage 1, buffer read
    ////////////////////////////////////////
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            active   <= 1'b0;
            cnt      <= '0;
            v2       <= 1'b0;
            seq_done <= 1'b0;
        end else begin
            seq_done <= 1'b0;
            if (seq_start) begin
                active <= 1'b1;
                cnt    <= '0;
                v2     <= 1'b0;
            end else if (active) begin
                if (issue) begin
                    cnt <= cnt + 1'b1;
                end
                v2 <= issue;
                if (!issue && v2) begin
                    active   <= 1'b0;
                    seq_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            widx <= cnt[BUF_AW-1:0];
        end
    end

    assign ifm_re    = issue;
    assign ifm_raddr = cnt[BUF_AW-1:0];

    ////////////////////////////////////////
    // stage 2, operate and write
    ////////////////////////////////////////
    always_comb begin
        // one extra bit catches signed overflow
        sum = {ifm_rdata[DATA_W-1], ifm_rdata} + {cfg.bias[DATA_W-1], cfg.bias};
        case (cfg.opcode)
            OP_PASS:  result = ifm_rdata;
            OP_RELU:  result = ifm_rdata[DATA_W-1] ? '0 : ifm_rdata;
            OP_BIAS: begin
                if (sum[DATA_W] != sum[DATA_W-1]) begin
                    result = sum[DATA_W] ? SAT_MIN : SAT_MAX;
                end else begin
                    result = sum[DATA_W-1:0];
                end
            end
            OP_HALVE: result = {ifm_rdata[DATA_W-1], ifm_rdata[DATA_W-1:1]};
            default:  result = ifm_rdata;
        endcase
    end

    assign ofm_we    = v2;
    assign ofm_waddr = widx;
    assign ofm_wdata = result;

endmodule

//--- cu_top.sv
`timescale 1ns/100ps

module cu_top
    import cu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              csr_we,
    input  cu_csr_addr_t      csr_addr,
    input  logic [DATA_W-1:0] csr_wdata,
    input  logic [DATA_W-1:0] mem_rdata,
    output logic              mem_rd_en,
    output logic              mem_wr_en,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [DATA_W-1:0] mem_wdata,
    output logic              busy,
    output logic              layer_done,
    output logic              phase_fetch,
    output logic              phase_compute,
    output logic              phase_writeback
);

    layer_cfg_t        cfg;
    logic              start_decoded;
    mem_req_t          rd_req;
    mem_req_t          wr_req;
    logic              mem_read_done;
    logic              mem_write_done;
    logic              seq_start;
    logic              seq_done;

    // ifm buffer, written by the mover and read by the sequencer
    logic              ifm_we;
    logic [BUF_AW-1:0] ifm_waddr;
    logic [DATA_W-1:0] ifm_wdata;
    logic              ifm_re;
    logic [BUF_AW-1:0] ifm_raddr;
    logic [DATA_W-1:0] ifm_rdata;

    // ofm buffer, written by the sequencer and read by the mover
    logic              ofm_we;
    logic [BUF_AW-1:0] ofm_waddr;
    logic [DATA_W-1:0] ofm_wdata;
    logic              ofm_re;
    logic [BUF_AW-1:0] ofm_raddr;
    logic [DATA_W-1:0] ofm_rdata;

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////
    cu_csr csr_i (
        .clk, .rst, .csr_we, .csr_addr, .csr_wdata,
        .cfg, .start_decoded
    );

    cu_fsm fsm_i (
        .clk, .rst, .start_decoded, .cfg, .mem_read_done, .mem_write_done, .seq_done,
        .rd_req, .wr_req, .seq_start, .phase_fetch, .phase_compute, .phase_writeback,
        .busy, .layer_done
    );

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////
    cu_dma dma_i (
        .clk, .rst, .rd_req, .wr_req, .mem_rdata, .ofm_rdata,
        .mem_read_done, .mem_write_done, .mem_rd_en, .mem_wr_en, .mem_addr, .mem_wdata,
        .ifm_we, .ifm_waddr, .ifm_wdata, .ofm_re, .ofm_raddr
    );

    cu_sequencer seq_i (
        .clk, .rst, .seq_start, .cfg, .ifm_rdata,
        .seq_done, .ifm_re, .ifm_raddr, .ofm_we, .ofm_waddr, .ofm_wdata
    );

    cu_scratch ifm_buf_i (
        .clk, .we(ifm_we), .waddr(ifm_waddr), .wdata(ifm_wdata),
        .re(ifm_re), .raddr(ifm_raddr), .rdata(ifm_rdata)
    );

    cu_scratch ofm_buf_i (
        .clk, .we(ofm_we), .waddr(ofm_waddr), .wdata(ofm_wdata),
        .re(ofm_re), .raddr(ofm_raddr), .rdata(ofm_rdata)
    );

endmodule

//--- tb_cu_top.sv
`timescale 1ns/100ps

module tb_cu_top
    import cu_pkg::*;
();

    logic              clk;
    logic              rst;
    logic              csr_we;
    cu_csr_addr_t      csr_addr;
    logic [DATA_W-1:0] csr_wdata;
    logic [DATA_W-1:0] mem_rdata = '0;
    logic              mem_rd_en;
    logic              mem_wr_en;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic              busy;
    logic              layer_done;
    logic              phase_fetch;
    logic              phase_compute;
    logic              phase_writeback;

    logic [DATA_W-1:0] ext_mem [1 << ADDR_W];
    logic [DATA_W-1:0] exp_mem [1 << ADDR_W];
    int                seed;
    int                done_cnt = 0;
    int                done_before;
    // worst case layer is three phases of len + 2 plus register writes
    int                layer_cycles = 3 * (BUF_DEPTH + 2) + 60;

    cu_top dut_i (
        .clk, .rst, .csr_we, .csr_addr, .csr_wdata, .mem_rdata,
        .mem_rd_en, .mem_wr_en, .mem_addr, .mem_wdata,
        .busy, .layer_done, .phase_fetch, .phase_compute, .phase_writeback
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // external memory with one cycle read latency
    always @(posedge clk) begin
        if (mem_wr_en) begin
            ext_mem[mem_addr] <= mem_wdata;
        end
        if (mem_rd_en) begin
            mem_rdata <= ext_mem[mem_addr];
        end
    end

    always @(negedge clk) begin
        if (layer_done) begin
            done_cnt++;
        end
    end

    // any bound protocol assertion failure ends the run
    always @(negedge clk) begin
        if (dut_i.assert_i.fail_cnt != 0) begin
            $display("a protocol assertion on the DUT failed");
            stop_on_failure();
        end
    end

    initial begin
        #(12 * layer_cycles * 4);
        $display("timeout: the layers did not finish in the expected time");
        stop_on_failure();
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    task automatic stop_on_failure();
        $display("test failed");
        $fatal(1);
    endtask

    function automatic logic [DATA_W-1:0] expected_word(input cu_opcode_t op,
                                                        input logic [DATA_W-1:0] x,
                                                        input logic [DATA_W-1:0] b);
        int sx;
        int sb;
        int s;
        sx = $signed(x);
        sb = $signed(b);
        case (op)
            OP_RELU:  s = (sx < 0) ? 0 : sx;
            OP_BIAS:  s = (sx + sb > 32767) ? 32767 : (sx + sb < -32768) ? -32768 : sx + sb;
            OP_HALVE: s = sx >>> 1;
            default:  s = sx;
        endcase
        return DATA_W'(s);
    endfunction

    function automatic int count_matches(input logic [ADDR_W-1:0] base, input int len,
                                         input logic [DATA_W-1:0] value);
        int n;
        n = 0;
        for (int i = 0; i < len; i++) begin
            if (ext_mem[ADDR_W'(base + i)] === value) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic csr_write(input cu_csr_addr_t addr, input logic [DATA_W-1:0] data);
        @(posedge clk);
        #1;
        csr_we    = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        @(posedge clk);
        #1;
        csr_we = 1'b0;
    endtask

    task automatic program_layer(input logic [ADDR_W-1:0] ifm_base,
                                 input logic [ADDR_W-1:0] ofm_base,
                                 input logic [LEN_W-1:0] ifm_len,
                                 input logic [LEN_W-1:0] ofm_len,
                                 input cu_opcode_t op, input logic [DATA_W-1:0] bias);
        csr_write(CSR_IFM_BASE, DATA_W'(ifm_base));
        csr_write(CSR_OFM_BASE, DATA_W'(ofm_base));
        csr_write(CSR_LEN, {1'b0, ofm_len, 1'b0, ifm_len});
        csr_write(CSR_OPCODE, DATA_W'(op));
        csr_write(CSR_BIAS, bias);
        // ofm word i is the operation applied to ifm word i
        exp_mem = ext_mem;
        for (int i = 0; i < ofm_len; i++) begin
            exp_mem[ADDR_W'(ofm_base + i)] = expected_word(op, ext_mem[ADDR_W'(ifm_base + i)],
                                                           bias);
        end
    endtask

    task automatic wait_layer_done();
        do @(negedge clk); while (!layer_done);
    endtask

    task automatic wait_compute();
        do @(negedge clk); while (!phase_compute);
    endtask

    task automatic check_memory();
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            assert (ext_mem[a] === exp_mem[a]) else begin
                $display("ERROR mem_word addr=%03h expected=%04h actual=%04h",
                         a, exp_mem[a], ext_mem[a]);
                stop_on_failure();
            end
        end
    endtask

    task automatic run_layer(input logic [ADDR_W-1:0] ifm_base,
                             input logic [ADDR_W-1:0] ofm_base,
                             input logic [LEN_W-1:0] ifm_len,
                             input logic [LEN_W-1:0] ofm_len,
                             input cu_opcode_t op, input logic [DATA_W-1:0] bias);
        program_layer(ifm_base, ofm_base, ifm_len, ofm_len, op, bias);
        csr_write(CSR_CTRL, 16'h0001);
        wait_layer_done();
        check_memory();
    endtask

    task automatic expect_low(input string name, input logic value);
        assert (value === 1'b0) else begin
            $display("ERROR %s expected=0 actual=%0h", name, value);
            stop_on_failure();
        end
    endtask

    task automatic expect_saturation(input logic [ADDR_W-1:0] base,
                                     input logic [DATA_W-1:0] value);
        assert (count_matches(base, BUF_DEPTH, value) > 0) else begin
            $display("no output word of the bias layer saturated to %04h", value);
            stop_on_failure();
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    initial begin
        rst       = 1'b1;
        csr_we    = 1'b0;
        csr_addr  = CSR_CTRL;
        csr_wdata = '0;
        seed      = 98183;
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            ext_mem[a] = DATA_W'($random(seed));
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // element-wise operations on full buffers
        run_layer(12'h100, 12'h400, 7'd64, 7'd64, OP_PASS, 16'h0000);
        run_layer(12'h100, 12'h480, 7'd64, 7'd64, OP_RELU, 16'h0000);
        run_layer(12'h200, 12'h500, 7'd64, 7'd64, OP_HALVE, 16'h0000);

        // bias with saturation both ways
        run_layer(12'h300, 12'h600, 7'd64, 7'd64, OP_BIAS, 16'h7000);
        expect_saturation(12'h600, 16'h7fff);
        run_layer(12'h300, 12'h680, 7'd64, 7'd64, OP_BIAS, 16'h9000);
        expect_saturation(12'h680, 16'h8000);

        // short output region
        run_layer(12'h700, 12'h800, 7'd40, 7'd10, OP_RELU, 16'h0000);

        // second go while busy
        program_layer(12'h900, 12'ha00, 7'd64, 7'd64, OP_HALVE, 16'h0000);
        done_before = done_cnt;
        csr_write(CSR_CTRL, 16'h0001);
        wait_compute();
        csr_write(CSR_CTRL, 16'h0001);
        wait_layer_done();
        repeat (layer_cycles) @(negedge clk);
        assert (done_cnt == done_before + 1) else begin
            $display("ERROR done_cnt expected=%0h actual=%0h", done_before + 1, done_cnt);
            stop_on_failure();
        end
        expect_low("busy", busy);
        check_memory();

        // reset in mid compute before any write
        program_layer(12'hb00, 12'hc00, 7'd64, 7'd64, OP_PASS, 16'h0000);
        exp_mem = ext_mem;
        csr_write(CSR_CTRL, 16'h0001);
        wait_compute();
        repeat (10) @(negedge clk);
        @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (3) @(negedge clk);
        expect_low("busy", busy);
        expect_low("phase_fetch", phase_fetch);
        expect_low("phase_compute", phase_compute);
        expect_low("phase_writeback", phase_writeback);
        expect_low("mem_rd_en", mem_rd_en);
        expect_low("mem_wr_en", mem_wr_en);
        expect_low("layer_done", layer_done);
        @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        expect_low("busy", busy);
        check_memory();
        run_layer(12'hb00, 12'hc00, 7'd64, 7'd64, OP_BIAS, 16'h0123);

        // bound assertions still sample the last layer_done
        repeat (2) @(negedge clk);

        if (dut_i.assert_i.fail_cnt != 0) begin
            $display("a protocol assertion on the DUT failed");
            stop_on_failure();
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- vlog.f
cu_pkg.sv
cu_scratch.sv
cu_csr.sv
cu_fsm.sv
cu_dma.sv
cu_sequencer.sv
cu_top.sv
cu_assertions.sv
tb_cu_top.sv
